// File: bridge_pkg.sv
package bridge_pkg;

    // serial timing
    localparam int CLKS_PER_BAUD = 33;
    // wide enough for one and a half bit times
    localparam int BAUD_CW = $clog2(2 * CLKS_PER_BAUD);

    // request bus and memory geometry
    localparam int BUS_AW = 16;
    localparam int BUS_DW = 16;
    localparam int MEM_DEPTH = 16384;
    localparam int MEM_AW = 14;
    localparam int MEM_DW = 12;
    localparam int READ_LATENCY = 2;

    typedef logic [BUS_AW-1:0] bus_addr_t;
    typedef logic [BUS_DW-1:0] bus_data_t;
    typedef logic [MEM_AW-1:0] mem_addr_t;
    typedef logic [MEM_DW-1:0] mem_data_t;

    // protocol characters
    localparam logic [7:0] CHAR_READ = 8'h52;
    localparam logic [7:0] CHAR_WRITE = 8'h57;
    localparam logic [7:0] CHAR_DATA = 8'h44;
    localparam logic [7:0] CHAR_CR = 8'h0D;
    localparam logic [7:0] CHAR_LF = 8'h0A;

    typedef enum logic [1:0] {PARSE_IDLE, PARSE_READ, PARSE_WRITE} parse_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_DATA, RX_STOP} rx_state_e;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    // upper-case hex only
    function automatic logic is_hex(input logic [7:0] c);
        return ((c >= 8'h30) && (c <= 8'h39)) || ((c >= 8'h41) && (c <= 8'h46));
    endfunction

    function automatic logic [3:0] hex_to_nibble(input logic [7:0] c);
        logic [7:0] v;
        if (c <= 8'h39) begin
            v = c - 8'h30;
        end else begin
            // 'A' minus ten
            v = c - 8'h37;
        end
        return v[3:0];
    endfunction

    function automatic logic [7:0] nibble_to_hex(input logic [3:0] n);
        if (n < 4'd10) begin
            return {4'h3, n};
        end
        return 8'h37 + {4'h0, n};
    endfunction

endpackage

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       rx_i,
    output logic [7:0] rx_data_o,
    output logic       rx_valid_o
);

    logic rx_meta;
    logic rx_sync;
    bridge_pkg::rx_state_e state;
    logic [bridge_pkg::BAUD_CW-1:0] baud_cnt;
    logic [2:0] bit_cnt;
    logic sample;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    assign sample = (baud_cnt == '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= bridge_pkg::RX_IDLE;
            baud_cnt <= '0;
            bit_cnt <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            case (state)
                bridge_pkg::RX_IDLE: begin
                    if (!rx_sync) begin
                        // skip the start bit and land mid bit 0
                        state <= bridge_pkg::RX_DATA;
                        baud_cnt <= bridge_pkg::BAUD_CW'(bridge_pkg::CLKS_PER_BAUD
                            + bridge_pkg::CLKS_PER_BAUD / 2 - 1);
                        bit_cnt <= '0;
                    end
                end
                bridge_pkg::RX_DATA: begin
                    if (sample) begin
                        baud_cnt <= bridge_pkg::BAUD_CW'(bridge_pkg::CLKS_PER_BAUD - 1);
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= bridge_pkg::RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                bridge_pkg::RX_STOP: begin
                    if (sample) begin
                        state <= bridge_pkg::RX_IDLE;
                        // framing error drops the byte
                        rx_valid_o <= rx_sync;
                    end else begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                default: state <= bridge_pkg::RX_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if ((state == bridge_pkg::RX_DATA) && sample) begin
            rx_data_o <= {rx_sync, rx_data_o[7:1]};
        end
    end

    a_rx_single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        rx_valid_o |=> !rx_valid_o);

endmodule

// File: cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [7:0]            rx_data_i,
    input  logic                  rx_valid_i,
    output bridge_pkg::bus_addr_t req_addr_o,
    output bridge_pkg::bus_data_t req_wdata_o,
    output logic                  req_write_o,
    output logic                  req_valid_o
);

    bridge_pkg::parse_state_e state;
    logic [3:0] char_cnt;
    logic [3:0] last_pos;
    logic [3:0] nibble;
    logic in_cmd;
    logic at_end;
    logic is_term;
    logic shift_en;

    // terminator position, after 4 or 8 hex digits
    assign last_pos = (state == bridge_pkg::PARSE_WRITE) ? 4'd8 : 4'd4;
    assign in_cmd = (state == bridge_pkg::PARSE_READ) || (state == bridge_pkg::PARSE_WRITE);
    assign at_end = (char_cnt == last_pos);
    assign is_term = (rx_data_i == bridge_pkg::CHAR_CR) || (rx_data_i == bridge_pkg::CHAR_LF);
    assign nibble = bridge_pkg::hex_to_nibble(rx_data_i);
    assign shift_en = rx_valid_i && in_cmd && !at_end && bridge_pkg::is_hex(rx_data_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= bridge_pkg::PARSE_IDLE;
            char_cnt <= '0;
            req_write_o <= 1'b0;
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= 1'b0;
            if (rx_valid_i) begin
                case (state)
                    bridge_pkg::PARSE_IDLE: begin
                        char_cnt <= '0;
                        if (rx_data_i == bridge_pkg::CHAR_READ) begin
                            state <= bridge_pkg::PARSE_READ;
                            req_write_o <= 1'b0;
                        end else if (rx_data_i == bridge_pkg::CHAR_WRITE) begin
                            state <= bridge_pkg::PARSE_WRITE;
                            req_write_o <= 1'b1;
                        end
                    end
                    bridge_pkg::PARSE_READ, bridge_pkg::PARSE_WRITE: begin
                        if (at_end) begin
                            state <= bridge_pkg::PARSE_IDLE;
                            req_valid_o <= is_term;
                        end else if (shift_en) begin
                            char_cnt <= char_cnt + 4'd1;
                        end else begin
                            // bad digit, give up quietly
                            state <= bridge_pkg::PARSE_IDLE;
                        end
                    end
                    default: state <= bridge_pkg::PARSE_IDLE;
                endcase
            end
        end
    end

    // first four digits are the address, the rest the data
    always_ff @(posedge clk) begin
        if (shift_en) begin
            if (char_cnt < 4'd4) begin
                req_addr_o <= {req_addr_o[bridge_pkg::BUS_AW-5:0], nibble};
            end else begin
                req_wdata_o <= {req_wdata_o[bridge_pkg::BUS_DW-5:0], nibble};
            end
        end
    end

    a_req_single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_valid_o |=> !req_valid_o);

    a_legal_state: assert property (@(posedge clk) disable iff (!rst_n_i)
        state inside {bridge_pkg::PARSE_IDLE, bridge_pkg::PARSE_READ,
                      bridge_pkg::PARSE_WRITE});

endmodule

// File: mem_core.sv
`timescale 1ns/1ps

module mem_core (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  bridge_pkg::bus_addr_t req_addr_i,
    input  bridge_pkg::bus_data_t req_wdata_i,
    input  logic                  req_write_i,
    input  logic                  req_valid_i,
    input  bridge_pkg::mem_addr_t user_addr_i,
    input  bridge_pkg::mem_data_t user_din_i,
    input  logic                  user_we_i,
    output bridge_pkg::bus_data_t rsp_data_o,
    output logic                  rsp_valid_o,
    output bridge_pkg::mem_data_t user_dout_o
);

    bridge_pkg::mem_data_t mem [bridge_pkg::MEM_DEPTH];
    bridge_pkg::mem_data_t bus_rd_q [bridge_pkg::READ_LATENCY];
    bridge_pkg::mem_data_t user_rd_q [bridge_pkg::READ_LATENCY];
    logic [bridge_pkg::READ_LATENCY-1:0] vld_q;
    logic [bridge_pkg::READ_LATENCY-1:0] rng_q;
    bridge_pkg::mem_addr_t bus_addr;
    logic req_in_range;
    logic bus_we;

    assign req_in_range = (32'(req_addr_i) < bridge_pkg::MEM_DEPTH);
    assign bus_addr = req_addr_i[bridge_pkg::MEM_AW-1:0];
    assign bus_we = req_valid_i && req_write_i && req_in_range;

    // start from a cleared memory, as the block RAM does after configuration
    initial begin
        for (int i = 0; i < bridge_pkg::MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // read-first on both ports
    // the bus write comes last so it wins on an address collision
    always @(posedge clk) begin
        if (user_we_i) begin
            mem[user_addr_i] <= user_din_i;
        end
        if (bus_we) begin
            mem[bus_addr] <= req_wdata_i[bridge_pkg::MEM_DW-1:0];
        end
        bus_rd_q[0] <= mem[bus_addr];
        user_rd_q[0] <= mem[user_addr_i];
        rng_q[0] <= req_in_range;
        for (int i = 1; i < bridge_pkg::READ_LATENCY; i++) begin
            bus_rd_q[i] <= bus_rd_q[i-1];
            user_rd_q[i] <= user_rd_q[i-1];
            rng_q[i] <= rng_q[i-1];
        end
    end

    // only reads produce a response
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[bridge_pkg::READ_LATENCY-2:0], req_valid_i && !req_write_i};
        end
    end

    assign rsp_valid_o = vld_q[bridge_pkg::READ_LATENCY-1];
    // out of range reads as zero, upper bits zero-extended
    assign rsp_data_o = rng_q[bridge_pkg::READ_LATENCY-1]
        ? {{(bridge_pkg::BUS_DW - bridge_pkg::MEM_DW){1'b0}},
           bus_rd_q[bridge_pkg::READ_LATENCY-1]}
        : '0;
    assign user_dout_o = user_rd_q[bridge_pkg::READ_LATENCY-1];

    a_rsp_follows_read: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_valid_o |-> $past(req_valid_i && !req_write_i, bridge_pkg::READ_LATENCY));

endmodule

// File: resp_formatter.sv
`timescale 1ns/1ps

module resp_formatter (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  bridge_pkg::bus_data_t rsp_data_i,
    input  logic                  rsp_valid_i,
    input  logic                  tx_ready_i,
    output logic [7:0]            tx_data_o,
    output logic                  tx_start_o
);

    bridge_pkg::bus_data_t act_data;
    bridge_pkg::bus_data_t pend_data;
    logic act_valid;
    logic pend_valid;
    logic [2:0] byte_pos;
    logic take;
    logic last;
    logic free_act;
    logic pend_load;

    assign take = tx_start_o && tx_ready_i;
    assign last = take && (byte_pos == 3'd6);
    // active slot is empty or finishing its LF this cycle
    assign free_act = !act_valid || last;
    // a full pending slot only accepts when it drains this cycle
    assign pend_load = rsp_valid_i && (!pend_valid || free_act);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            act_valid <= 1'b0;
            pend_valid <= 1'b0;
            byte_pos <= '0;
        end else begin
            pend_valid <= pend_load || (pend_valid && !free_act);
            if (free_act && pend_valid) begin
                act_valid <= 1'b1;
            end else if (last) begin
                act_valid <= 1'b0;
            end
            if (last) begin
                byte_pos <= '0;
            end else if (take) begin
                byte_pos <= byte_pos + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pend_load) begin
            pend_data <= rsp_data_i;
        end
        if (free_act && pend_valid) begin
            act_data <= pend_data;
        end
    end

    assign tx_start_o = act_valid;

    // reply is D, four hex digits, CR, LF
    always_comb begin
        case (byte_pos)
            3'd0: tx_data_o = bridge_pkg::CHAR_DATA;
            3'd1: tx_data_o = bridge_pkg::nibble_to_hex(act_data[15:12]);
            3'd2: tx_data_o = bridge_pkg::nibble_to_hex(act_data[11:8]);
            3'd3: tx_data_o = bridge_pkg::nibble_to_hex(act_data[7:4]);
            3'd4: tx_data_o = bridge_pkg::nibble_to_hex(act_data[3:0]);
            3'd5: tx_data_o = bridge_pkg::CHAR_CR;
            default: tx_data_o = bridge_pkg::CHAR_LF;
        endcase
    end

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic [7:0] tx_data_i,
    input  logic       tx_start_i,
    output logic       tx_ready_o,
    output logic       tx_o
);

    bridge_pkg::tx_state_e state;
    logic [bridge_pkg::BAUD_CW-1:0] baud_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] shreg;
    logic bit_end;

    assign tx_ready_o = (state == bridge_pkg::TX_IDLE);
    assign bit_end = (baud_cnt == '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= bridge_pkg::TX_IDLE;
            baud_cnt <= '0;
            bit_cnt <= '0;
            tx_o <= 1'b1;
        end else begin
            if (state != bridge_pkg::TX_IDLE) begin
                baud_cnt <= bit_end
                    ? bridge_pkg::BAUD_CW'(bridge_pkg::CLKS_PER_BAUD - 1)
                    : baud_cnt - 1'b1;
            end
            case (state)
                bridge_pkg::TX_IDLE: begin
                    if (tx_start_i) begin
                        // start bit goes out right away
                        state <= bridge_pkg::TX_START;
                        baud_cnt <= bridge_pkg::BAUD_CW'(bridge_pkg::CLKS_PER_BAUD - 1);
                        tx_o <= 1'b0;
                    end
                end
                bridge_pkg::TX_START: begin
                    if (bit_end) begin
                        state <= bridge_pkg::TX_DATA;
                        bit_cnt <= '0;
                        tx_o <= shreg[0];
                    end
                end
                bridge_pkg::TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= bridge_pkg::TX_STOP;
                            tx_o <= 1'b1;
                        end else begin
                            tx_o <= shreg[0];
                        end
                    end
                end
                bridge_pkg::TX_STOP: begin
                    if (bit_end) begin
                        state <= bridge_pkg::TX_IDLE;
                    end
                end
                default: state <= bridge_pkg::TX_IDLE;
            endcase
        end
    end

    // shift register feeds tx_o lsb first
    always_ff @(posedge clk) begin
        if (tx_ready_o && tx_start_i) begin
            shreg <= tx_data_i;
        end else if (bit_end && ((state == bridge_pkg::TX_START)
                                 || (state == bridge_pkg::TX_DATA))) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n_i)
        tx_ready_o |-> tx_o);

endmodule

// File: uart_mem_bridge.sv
`timescale 1ns/1ps

module uart_mem_bridge (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        rx_i,
    output logic        tx_o,
    input  logic [13:0] user_addr_i,
    input  logic [11:0] user_din_i,
    input  logic        user_we_i,
    output logic [11:0] user_dout_o
);

    logic [7:0] rx_data;
    logic rx_valid;
    logic [15:0] req_addr;
    logic [15:0] req_wdata;
    logic req_write;
    logic req_valid;
    logic [15:0] rsp_data;
    logic rsp_valid;
    logic [7:0] tx_data;
    logic tx_start;
    logic tx_ready;

    uart_rx uart_rx_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rx_i       (rx_i),
        .rx_data_o  (rx_data),
        .rx_valid_o (rx_valid)
    );

    cmd_parser cmd_parser_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rx_data_i   (rx_data),
        .rx_valid_i  (rx_valid),
        .req_addr_o  (req_addr),
        .req_wdata_o (req_wdata),
        .req_write_o (req_write),
        .req_valid_o (req_valid)
    );

    mem_core mem_core_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .req_write_i (req_write),
        .req_valid_i (req_valid),
        .user_addr_i (user_addr_i),
        .user_din_i  (user_din_i),
        .user_we_i   (user_we_i),
        .rsp_data_o  (rsp_data),
        .rsp_valid_o (rsp_valid),
        .user_dout_o (user_dout_o)
    );

    resp_formatter resp_formatter_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rsp_data_i  (rsp_data),
        .rsp_valid_i (rsp_valid),
        .tx_ready_i  (tx_ready),
        .tx_data_o   (tx_data),
        .tx_start_o  (tx_start)
    );

    uart_tx uart_tx_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .tx_data_i  (tx_data),
        .tx_start_i (tx_start),
        .tx_ready_o (tx_ready),
        .tx_o       (tx_o)
    );

endmodule

// File: tb_uart_mem_bridge.sv
`timescale 1ns/1ps

module tb_uart_mem_bridge;

    localparam int BIT_CYCLES = bridge_pkg::CLKS_PER_BAUD;
    localparam int BYTE_CYCLES = 10 * BIT_CYCLES;
    localparam int BYTE_NS = BYTE_CYCLES * 10;
    // serial bytes moved by all tests together, rounded up
    localparam int EST_BYTES = 380;
    localparam int WATCHDOG_NS = 5 * EST_BYTES * BYTE_NS / 2;
    localparam int RECV_TIMEOUT = 12 * BYTE_CYCLES;
    // request lands well inside the stop bit, this covers the memory pipeline
    localparam int SETTLE_CYCLES = bridge_pkg::READ_LATENCY + 1 + 8;
    localparam logic [31:0] SEED = 32'd33821;
    localparam bridge_pkg::bus_data_t MEM_MASK =
        bridge_pkg::bus_data_t'((1 << bridge_pkg::MEM_DW) - 1);

    logic clk;
    logic rst_n_i;
    logic rx_i;
    logic tx_o;
    bridge_pkg::mem_addr_t user_addr_i;
    bridge_pkg::mem_data_t user_din_i;
    logic user_we_i;
    bridge_pkg::mem_data_t user_dout_o;

    int errors;
    int checks;
    logic [31:0] lcg_state;

    uart_mem_bridge uart_mem_bridge_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rx_i        (rx_i),
        .tx_o        (tx_o),
        .user_addr_i (user_addr_i),
        .user_din_i  (user_din_i),
        .user_we_i   (user_we_i),
        .user_dout_o (user_dout_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        if (n < 4'd10) begin
            return 8'h30 + {4'h0, n};
        end
        return 8'h41 + {4'h0, n} - 8'd10;
    endfunction

    // reply digits are upper case only
    function automatic logic [3:0] hex_value(input logic [7:0] c);
        logic [7:0] v;
        if (c >= 8'h41) begin
            v = c - 8'h41 + 8'd10;
        end else begin
            v = c - 8'h30;
        end
        return v[3:0];
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0d ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input bridge_pkg::bus_data_t exp,
                              input bridge_pkg::bus_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0d ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_mem(input string name, input bridge_pkg::mem_data_t exp,
                             input bridge_pkg::mem_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0d ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // start bit, eight data bits lsb first, stop bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx_i = frame[i];
            repeat (BIT_CYCLES - 1) @(negedge clk);
        end
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            send_byte(s[i]);
        end
    endtask

    task automatic send_read(input bridge_pkg::bus_addr_t addr, input logic [7:0] term);
        send_byte(bridge_pkg::CHAR_READ);
        for (int i = 3; i >= 0; i--) begin
            send_byte(hex_char(addr[i*4 +: 4]));
        end
        send_byte(term);
    endtask

    task automatic send_write(input bridge_pkg::bus_addr_t addr, input bridge_pkg::bus_data_t data,
                              input logic [7:0] term);
        send_byte(bridge_pkg::CHAR_WRITE);
        for (int i = 3; i >= 0; i--) begin
            send_byte(hex_char(addr[i*4 +: 4]));
        end
        for (int i = 3; i >= 0; i--) begin
            send_byte(hex_char(data[i*4 +: 4]));
        end
        send_byte(term);
    endtask

    task automatic recv_byte(output logic [7:0] b, output bit ok);
        int waited;
        logic [7:0] shift;
        waited = 0;
        shift = '0;
        @(negedge clk);
        while ((tx_o !== 1'b0) && (waited < RECV_TIMEOUT)) begin
            @(negedge clk);
            waited++;
        end
        ok = (tx_o === 1'b0);
        if (ok) begin
            // middle of the start bit, then one bit time per sample
            repeat (BIT_CYCLES / 2) @(negedge clk);
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CYCLES) @(negedge clk);
                shift = {tx_o, shift[7:1]};
            end
            repeat (BIT_CYCLES) @(negedge clk);
            if (tx_o !== 1'b1) begin
                errors++;
                $display("stop bit on tx_o was low at %0d ns", $time);
            end
        end
        b = shift;
    endtask

    // the reply starts during the stop bit of the command, so listen while sending
    task automatic read_and_check(input bridge_pkg::bus_addr_t addr,
                                  input bridge_pkg::bus_data_t exp, input logic [7:0] term);
        logic [7:0] got [7];
        logic [7:0] want [7];
        bridge_pkg::bus_data_t word;
        bit ok;
        want[0] = bridge_pkg::CHAR_DATA;
        want[1] = hex_char(exp[15:12]);
        want[2] = hex_char(exp[11:8]);
        want[3] = hex_char(exp[7:4]);
        want[4] = hex_char(exp[3:0]);
        want[5] = bridge_pkg::CHAR_CR;
        want[6] = bridge_pkg::CHAR_LF;
        ok = 1'b1;
        fork
            send_read(addr, term);
            begin
                for (int i = 0; i < 7; i++) begin
                    if (ok) begin
                        recv_byte(got[i], ok);
                    end
                end
            end
        join
        if (!ok) begin
            errors++;
            $display("no complete reply on tx_o for the read of address %h", addr);
        end else begin
            for (int i = 0; i < 7; i++) begin
                check_byte($sformatf("reply byte %0d", i), want[i], got[i]);
            end
            word = {hex_value(got[1]), hex_value(got[2]), hex_value(got[3]), hex_value(got[4])};
            check_word("reply word", exp, word);
        end
    endtask

    task automatic expect_silence(input string what);
        bit seen;
        seen = 1'b0;
        repeat (2 * BYTE_CYCLES) begin
            @(negedge clk);
            if (tx_o !== 1'b1) begin
                seen = 1'b1;
            end
        end
        checks++;
        if (seen) begin
            errors++;
            $display("a reply appeared on tx_o after the %s command", what);
        end
    endtask

    task automatic user_write(input bridge_pkg::mem_addr_t addr, input bridge_pkg::mem_data_t data);
        @(negedge clk);
        user_addr_i = addr;
        user_din_i = data;
        user_we_i = 1'b1;
        @(negedge clk);
        user_we_i = 1'b0;
    endtask

    task automatic user_read(input bridge_pkg::mem_addr_t addr,
                             output bridge_pkg::mem_data_t data);
        @(negedge clk);
        user_addr_i = addr;
        repeat (bridge_pkg::READ_LATENCY) @(negedge clk);
        data = user_dout_o;
    endtask

    task automatic test_write_read();
        send_write(16'h0123, 16'hBEEF, bridge_pkg::CHAR_CR);
        read_and_check(16'h0123, 16'hBEEF & MEM_MASK, bridge_pkg::CHAR_LF);
        send_write(16'h3FFE, 16'h0A5C, bridge_pkg::CHAR_LF);
        read_and_check(16'h3FFE, 16'h0A5C & MEM_MASK, bridge_pkg::CHAR_CR);
    endtask

    task automatic test_user_serial();
        bridge_pkg::mem_data_t got;
        user_write(14'h0200, 12'h7C3);
        read_and_check(16'h0200, 16'h07C3, bridge_pkg::CHAR_CR);
        send_write(16'h0345, 16'h1F0E, bridge_pkg::CHAR_CR);
        repeat (SETTLE_CYCLES) @(negedge clk);
        user_read(14'h0345, got);
        check_mem("user_dout_o", 12'hF0E, got);
    endtask

    task automatic test_malformed();
        send_write(16'h0040, 16'h0321, bridge_pkg::CHAR_CR);
        // lower-case digit
        send_text("R00a0");
        send_byte(bridge_pkg::CHAR_CR);
        expect_silence("lower-case read");
        send_text("W00405a5a");
        send_byte(bridge_pkg::CHAR_CR);
        // non-hex digit
        send_text("R0G40");
        send_byte(bridge_pkg::CHAR_CR);
        expect_silence("non-hex read");
        send_text("W0040G5A5");
        send_byte(bridge_pkg::CHAR_CR);
        // wrong terminator
        send_text("R0040.");
        expect_silence("badly terminated read");
        send_text("W004055AA.");
        // stray byte while idle
        send_text("X");
        expect_silence("stray byte");
        read_and_check(16'h0040, 16'h0321, bridge_pkg::CHAR_LF);
    endtask

    task automatic test_range();
        bridge_pkg::bus_addr_t oor;
        bridge_pkg::mem_data_t got;
        // give the aliased words nonzero contents
        user_write(14'h0000, 12'h9D1);
        user_write(14'h3FFF, 12'h2E4);
        read_and_check(16'h4000, 16'h0000, bridge_pkg::CHAR_CR);
        read_and_check(16'hFFFF, 16'h0000, bridge_pkg::CHAR_LF);
        oor = 16'h4005;
        user_write(oor[bridge_pkg::MEM_AW-1:0], 12'h5A6);
        send_write(oor, 16'h0ABC, bridge_pkg::CHAR_CR);
        repeat (SETTLE_CYCLES) @(negedge clk);
        user_read(oor[bridge_pkg::MEM_AW-1:0], got);
        check_mem("user_dout_o", 12'h5A6, got);
        read_and_check(oor, 16'h0000, bridge_pkg::CHAR_CR);
    endtask

    task automatic test_random();
        bridge_pkg::bus_addr_t addrs [8];
        bridge_pkg::bus_data_t datas [8];
        bridge_pkg::mem_data_t model [bridge_pkg::bus_addr_t];
        logic [7:0] term;
        for (int i = 0; i < 8; i++) begin
            lcg_state = lcg_next(lcg_state);
            addrs[i] = bridge_pkg::bus_addr_t'({16'h0, lcg_state[31:16]} % bridge_pkg::MEM_DEPTH);
            lcg_state = lcg_next(lcg_state);
            datas[i] = lcg_state[31:16];
            // the memory keeps only the low word bits
            model[addrs[i]] = bridge_pkg::mem_data_t'(datas[i]);
            term = (i % 2 == 1) ? bridge_pkg::CHAR_LF : bridge_pkg::CHAR_CR;
            send_write(addrs[i], datas[i], term);
        end
        for (int i = 0; i < 8; i++) begin
            term = (i % 2 == 0) ? bridge_pkg::CHAR_LF : bridge_pkg::CHAR_CR;
            read_and_check(addrs[i], bridge_pkg::bus_data_t'(model[addrs[i]]), term);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        lcg_state = SEED;
        rst_n_i = 1'b0;
        rx_i = 1'b1;
        user_addr_i = '0;
        user_din_i = '0;
        user_we_i = 1'b0;
        repeat (2) @(negedge clk);
        rst_n_i = 1'b1;
        repeat (5) @(negedge clk);
        test_write_read();
        test_user_serial();
        test_malformed();
        test_range();
        test_random();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verilog.f
bridge_pkg.sv
uart_rx.sv
cmd_parser.sv
mem_core.sv
resp_formatter.sv
uart_tx.sv
uart_mem_bridge.sv
tb_uart_mem_bridge.sv

// File: run.sh
#!/bin/sh
# builds and runs the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_uart_mem_bridge -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_uart_mem_bridge > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
exit 0
